//--- tb.f
src/conv_pkg.sv
src/conv_ctrl.sv
src/conv_addr_gen.sv
src/window_ring.sv
src/mac_unit.sv
src/conv_top.sv
testbench/tb_clkgen.sv
testbench/conv_sva.sv
testbench/tb_conv.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_conv -f tb.f -o tb_conv_sim
	./obj_dir/tb_conv_sim | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_conv.sv
`default_nettype none

module tb_conv;

  timeunit 1ns;
  timeprecision 1ps;

  import conv_pkg::*;

  localparam int WT_DIM  = 5;
  localparam int WT_SIZE = WT_DIM * WT_DIM;
  localparam int TIMEOUT = 100000;

  logic   clk;
  logic   rst_n;
  logic   start;
  logic   idle;
  logic   done;
  dim_t   ifm_dim;
  dim_t   ifm_depth;
  addr_t  wt_addr;
  pixel_t wt_dout;
  logic   wt_valid;
  logic   wt_ready;
  addr_t  ifm_addr;
  pixel_t ifm_dout;
  logic   ifm_valid;
  logic   ifm_ready;
  addr_t  ofm_rd_addr;
  acc_t   ofm_rd_dout;
  logic   ofm_rd_valid;
  logic   ofm_rd_ready;
  addr_t  ofm_wr_addr;
  acc_t   ofm_wr_data;
  logic   ofm_wr_valid;
  logic   ofm_wr_ready;

  pixel_t wt_mem  [256];
  pixel_t ifm_mem [256];
  acc_t   ofm_mem [64];

  // port state sampled at the falling edge and acted on at the next rising edge
  logic   wt_take;
  logic   wt_want;
  logic   ifm_take;
  logic   ifm_want;
  logic   rd_take;
  logic   rd_want;
  addr_t  wt_a;
  addr_t  ifm_a;
  addr_t  rd_a;
  int     wt_dly;
  int     ifm_dly;
  int     rd_dly;
  int     cur_dim;
  int     cur_ofm;
  int     cur_depth;
  int     wr_count;
  time    last_wr_time;

  tb_clkgen clkgen0 (.clk(clk), .rst_n(rst_n));

  conv_top #(.WT_DIM(WT_DIM)) dut0 (.*);

  task automatic fail_stop();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic report_error(input string msg);
    $display("%s at %0t", msg, $time);
    fail_stop();
  endtask

  task automatic check_acc(input string name, input acc_t got, input acc_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      fail_stop();
    end
  endtask

  // running sum over channels 0..last_ch of the window dot product
  function automatic acc_t model_sum(input int last_ch, input int pix);
    int oy;
    int ox;
    int s;
    oy = pix / cur_ofm;
    ox = pix % cur_ofm;
    s = 0;
    for (int c = 0; c <= last_ch; c++) begin
      for (int wy = 0; wy < WT_DIM; wy++) begin
        for (int wx = 0; wx < WT_DIM; wx++) begin
          s += int'(wt_mem[c * WT_SIZE + wy * WT_DIM + wx]) *
               int'(ifm_mem[c * cur_dim * cur_dim + (oy + wy) * cur_dim + ox + wx]);
        end
      end
    end
    return acc_t'(s);
  endfunction

  always @(negedge clk) begin
    wt_take  = wt_ready & wt_valid;
    wt_want  = wt_ready & ~wt_valid;
    wt_a     = wt_addr;
    ifm_take = ifm_ready & ifm_valid;
    ifm_want = ifm_ready & ~ifm_valid;
    ifm_a    = ifm_addr;
    rd_take  = ofm_rd_ready & ofm_rd_valid;
    rd_want  = ofm_rd_ready & ~ofm_rd_valid;
    rd_a     = ofm_rd_addr;
  end

  // read ports answer after a random delay and drop valid after each transfer
  always @(posedge clk) begin
    if (wt_take) begin
      wt_valid <= 1'b0;
    end else if (wt_want) begin
      if (wt_dly == 0) begin
        wt_valid <= 1'b1;
        wt_dout  <= wt_mem[wt_a];
        wt_dly   <= int'($urandom % 4);
      end else begin
        wt_dly <= wt_dly - 1;
      end
    end
    if (ifm_take) begin
      ifm_valid <= 1'b0;
    end else if (ifm_want) begin
      if (ifm_dly == 0) begin
        ifm_valid <= 1'b1;
        ifm_dout  <= ifm_mem[ifm_a];
        ifm_dly   <= int'($urandom % 4);
      end else begin
        ifm_dly <= ifm_dly - 1;
      end
    end
    if (rd_take) begin
      ofm_rd_valid <= 1'b0;
    end else if (rd_want) begin
      if (rd_dly == 0) begin
        ofm_rd_valid <= 1'b1;
        ofm_rd_dout  <= ofm_mem[rd_a];
        rd_dly       <= int'($urandom % 4);
      end else begin
        rd_dly <= rd_dly - 1;
      end
    end
    ofm_wr_ready <= (($urandom % 4) != 0);
  end

  // a write seen here transfers at the next rising edge
  always @(negedge clk) begin
    if (rst_n && ofm_wr_valid && ofm_wr_ready) begin
      if (wr_count >= cur_depth * cur_ofm * cur_ofm) begin
        report_error("more OFM writes than the run needs");
      end
      check_addr("ofm_wr_addr", ofm_wr_addr, addr_t'(wr_count % (cur_ofm * cur_ofm)));
      check_acc("ofm_wr_data", ofm_wr_data,
                model_sum(wr_count / (cur_ofm * cur_ofm), wr_count % (cur_ofm * cur_ofm)));
      ofm_mem[ofm_wr_addr] = ofm_wr_data;
      wr_count++;
      last_wr_time = $time;
    end
  end

  task automatic run_conv(input int dim, input int depth);
    int cycles;
    cur_dim   = dim;
    cur_ofm   = dim - WT_DIM + 1;
    cur_depth = depth;
    wr_count  = 0;
    for (int i = 0; i < 256; i++) begin
      wt_mem[i]  = pixel_t'($urandom);
      ifm_mem[i] = pixel_t'($urandom);
    end
    // stale OFM contents must never reach a channel 0 result
    for (int i = 0; i < 64; i++) begin
      ofm_mem[i] = acc_t'($urandom);
    end
    @(posedge clk);
    ifm_dim   <= dim_t'(dim);
    ifm_depth <= dim_t'(depth);
    start     <= 1'b1;
    @(negedge clk);
    check_bit("done", done, 1'b0);
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT) begin
        report_error("timed out waiting for done");
      end
    end
    if (wr_count != depth * cur_ofm * cur_ofm) begin
      report_error("done came before all OFM writes");
    end
    if ($time - last_wr_time != 10) begin
      report_error("done did not rise one cycle after the last write");
    end
    for (int p = 0; p < cur_ofm * cur_ofm; p++) begin
      check_acc("ofm_mem", ofm_mem[p], model_sum(depth - 1, p));
    end
    repeat (3) begin
      @(negedge clk);
      check_bit("done", done, 1'b1);
      check_bit("idle", idle, 1'b1);
    end
  endtask

  initial begin
    start        = 1'b0;
    ifm_dim      = dim_t'(WT_DIM);
    ifm_depth    = 16'd1;
    wt_dout      = '0;
    wt_valid     = 1'b0;
    ifm_dout     = '0;
    ifm_valid    = 1'b0;
    ofm_rd_dout  = '0;
    ofm_rd_valid = 1'b0;
    ofm_wr_ready = 1'b0;
    wt_dly       = 0;
    ifm_dly      = 0;
    rd_dly       = 0;
    cur_dim      = WT_DIM;
    cur_ofm      = 1;
    cur_depth    = 1;
    wr_count     = 0;
    last_wr_time = 0;
  end

  initial begin
    int cycles;
    void'($urandom(32'h5017_979e));
    cycles = 0;
    while (rst_n !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20) begin
        report_error("reset never released");
      end
    end
    @(negedge clk);
    check_bit("idle", idle, 1'b1);
    check_bit("done", done, 1'b0);
    check_bit("wt_ready", wt_ready, 1'b0);
    check_bit("ifm_ready", ifm_ready, 1'b0);
    check_bit("ofm_rd_ready", ofm_rd_ready, 1'b0);
    check_bit("ofm_wr_valid", ofm_wr_valid, 1'b0);
    run_conv(WT_DIM + int'($urandom % 4), 1);
    run_conv(WT_DIM + int'($urandom % 4), 2 + int'($urandom % 2));
    run_conv(WT_DIM + int'($urandom % 4), 2 + int'($urandom % 2));
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/conv_sva.sv
`default_nettype none

module conv_sva (
  input logic            clk,
  input logic            rst_n,
  input logic            idle,
  input logic            done,
  input logic            wt_ready,
  input logic            wt_valid,
  input conv_pkg::addr_t wt_addr,
  input logic            ifm_ready,
  input logic            ifm_valid,
  input conv_pkg::addr_t ifm_addr,
  input logic            ofm_rd_ready,
  input logic            ofm_rd_valid,
  input conv_pkg::addr_t ofm_rd_addr,
  input logic            ofm_wr_valid,
  input logic            ofm_wr_ready,
  input conv_pkg::addr_t ofm_wr_addr,
  input conv_pkg::acc_t  ofm_wr_data
);

  timeunit 1ns;
  timeprecision 1ps;

  // request held without a transfer keeps its address
  wt_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (wt_ready && !wt_valid) |=> $stable(wt_addr))
    else $error("weight address moved while waiting");

  ifm_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (ifm_ready && !ifm_valid) |=> $stable(ifm_addr))
    else $error("IFM address moved while waiting");

  ofm_rd_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (ofm_rd_ready && !ofm_rd_valid) |=> $stable(ofm_rd_addr))
    else $error("OFM read address moved while waiting");

  ofm_wr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (ofm_wr_valid && !ofm_wr_ready) |=>
      (ofm_wr_valid && $stable(ofm_wr_addr) && $stable(ofm_wr_data)))
    else $error("OFM write dropped or changed before its transfer");

  no_fetch_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (idle || done) |-> !(wt_ready || ifm_ready || ofm_rd_ready))
    else $error("fetch ready high while idle or done");

  reset_state: assert property (@(posedge clk)
    !rst_n |-> (idle && !done && !wt_ready && !ifm_ready && !ofm_rd_ready && !ofm_wr_valid))
    else $error("outputs not in reset state");

endmodule

bind conv_top conv_sva sva0 (
  .clk         (clk),
  .rst_n       (rst_n),
  .idle        (idle),
  .done        (done),
  .wt_ready    (wt_ready),
  .wt_valid    (wt_valid),
  .wt_addr     (wt_addr),
  .ifm_ready   (ifm_ready),
  .ifm_valid   (ifm_valid),
  .ifm_addr    (ifm_addr),
  .ofm_rd_ready(ofm_rd_ready),
  .ofm_rd_valid(ofm_rd_valid),
  .ofm_rd_addr (ofm_rd_addr),
  .ofm_wr_valid(ofm_wr_valid),
  .ofm_wr_ready(ofm_wr_ready),
  .ofm_wr_addr (ofm_wr_addr),
  .ofm_wr_data (ofm_wr_data)
);

`default_nettype wire

//--- testbench/tb_clkgen.sv
`default_nettype none

module tb_clkgen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // reset held for two rising edges
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

//--- src/conv_top.sv
`default_nettype none

module conv_top #(
  parameter int WT_DIM = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             start,
  output logic             idle,
  output logic             done,
  input  conv_pkg::dim_t   ifm_dim,
  input  conv_pkg::dim_t   ifm_depth,
  // weight read
  output conv_pkg::addr_t  wt_addr,
  input  conv_pkg::pixel_t wt_dout,
  input  logic             wt_valid,
  output logic             wt_ready,
  // IFM read
  output conv_pkg::addr_t  ifm_addr,
  input  conv_pkg::pixel_t ifm_dout,
  input  logic             ifm_valid,
  output logic             ifm_ready,
  // OFM partial sum read
  output conv_pkg::addr_t  ofm_rd_addr,
  input  conv_pkg::acc_t   ofm_rd_dout,
  input  logic             ofm_rd_valid,
  output logic             ofm_rd_ready,
  // OFM write
  output conv_pkg::addr_t  ofm_wr_addr,
  output conv_pkg::acc_t   ofm_wr_data,
  output logic             ofm_wr_valid,
  input  logic             ofm_wr_ready
);

  import conv_pkg::*;

  phase_e phase;
  logic   xfer_wt;
  logic   xfer_ifm;
  logic   xfer_ofm;
  logic   xfer_wr;
  logic   window_last;
  logic   plane_last;
  logic   computing;
  logic   acc_clear;
  pixel_t wt_head;
  pixel_t ifm_head;

  // rings rotate and the MAC adds in the same cycles
  assign computing = (phase == COMPUTE);
  assign acc_clear = (phase == FETCH_IFM);

  conv_ctrl #(
    .WT_DIM(WT_DIM)
  ) ctrl0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .wt_valid    (wt_valid),
    .ifm_valid   (ifm_valid),
    .ofm_rd_valid(ofm_rd_valid),
    .ofm_wr_ready(ofm_wr_ready),
    .ifm_depth   (ifm_depth),
    .window_last (window_last),
    .plane_last  (plane_last),
    .phase       (phase),
    .wt_ready    (wt_ready),
    .ifm_ready   (ifm_ready),
    .ofm_rd_ready(ofm_rd_ready),
    .ofm_wr_valid(ofm_wr_valid),
    .xfer_wt     (xfer_wt),
    .xfer_ifm    (xfer_ifm),
    .xfer_ofm    (xfer_ofm),
    .xfer_wr     (xfer_wr),
    .idle        (idle),
    .done        (done)
  );

  conv_addr_gen #(
    .WT_DIM(WT_DIM)
  ) addr0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .phase      (phase),
    .xfer_wt    (xfer_wt),
    .xfer_ifm   (xfer_ifm),
    .xfer_wr    (xfer_wr),
    .ifm_dim    (ifm_dim),
    .wt_addr    (wt_addr),
    .ifm_addr   (ifm_addr),
    .ofm_rd_addr(ofm_rd_addr),
    .ofm_wr_addr(ofm_wr_addr),
    .window_last(window_last),
    .plane_last (plane_last)
  );

  window_ring #(
    .WT_DIM(WT_DIM)
  ) wt_ring (
    .clk  (clk),
    .rst_n(rst_n),
    .load (xfer_wt),
    .step (computing),
    .din  (wt_dout),
    .head (wt_head)
  );

  window_ring #(
    .WT_DIM(WT_DIM)
  ) ifm_ring (
    .clk  (clk),
    .rst_n(rst_n),
    .load (xfer_ifm),
    .step (computing),
    .din  (ifm_dout),
    .head (ifm_head)
  );

  mac_unit mac0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear       (acc_clear),
    .enable      (computing),
    .wt          (wt_head),
    .ifm         (ifm_head),
    .partial     (ofm_rd_dout),
    .partial_load(xfer_ofm),
    .sum         (ofm_wr_data)
  );

endmodule

`default_nettype wire

//--- src/mac_unit.sv
`default_nettype none

module mac_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clear,
  input  logic             enable,
  input  conv_pkg::pixel_t wt,
  input  conv_pkg::pixel_t ifm,
  input  conv_pkg::acc_t   partial,
  input  logic             partial_load,
  output conv_pkg::acc_t   sum
);

  import conv_pkg::*;

  logic signed [15:0] prod;
  acc_t               acc_q;
  acc_t               partial_q;
  logic               partial_held;

  assign prod = wt * ifm;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q        <= '0;
      partial_q    <= '0;
      partial_held <= 1'b0;
    end else begin
      if (clear) begin
        acc_q <= '0;
      end else if (enable) begin
        acc_q <= acc_q + acc_t'(prod);
      end

      // channel 0 has no OFM read, so its partial sum starts at zero
      if (partial_load) begin
        partial_q    <= partial;
        partial_held <= 1'b1;
      end else if (clear && !partial_held) begin
        partial_q <= '0;
      end else if (enable) begin
        partial_held <= 1'b0;
      end
    end
  end

  assign sum = partial_q + acc_q;

endmodule

`default_nettype wire

//--- src/window_ring.sv
`default_nettype none

module window_ring #(
  parameter int WT_DIM = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             load,
  input  logic             step,
  input  conv_pkg::pixel_t din,
  output conv_pkg::pixel_t head
);

  import conv_pkg::*;

  localparam int DEPTH = WT_DIM * WT_DIM;

  pixel_t ring_q [DEPTH];
  pixel_t tail_in;

  // memory data while loading, otherwise the head comes back around
  assign tail_in = load ? din : ring_q[0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        ring_q[i] <= '0;
      end
    end else if (load || step) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        ring_q[i] <= ring_q[i + 1];
      end
      ring_q[DEPTH - 1] <= tail_in;
    end
  end

  assign head = ring_q[0];

endmodule

`default_nettype wire

//--- src/conv_addr_gen.sv
`default_nettype none

module conv_addr_gen #(
  parameter int WT_DIM = 5
) (
  input  logic             clk,
  input  logic             rst_n,
  input  conv_pkg::phase_e phase,
  input  logic             xfer_wt,
  input  logic             xfer_ifm,
  input  logic             xfer_wr,
  input  conv_pkg::dim_t   ifm_dim,
  output conv_pkg::addr_t  wt_addr,
  output conv_pkg::addr_t  ifm_addr,
  output conv_pkg::addr_t  ofm_rd_addr,
  output conv_pkg::addr_t  ofm_wr_addr,
  output logic             window_last,
  output logic             plane_last
);

  import conv_pkg::*;

  localparam int WT_SIZE = WT_DIM * WT_DIM;

  dim_t  win_x;
  dim_t  win_y;
  dim_t  out_x;
  dim_t  out_y;
  dim_t  ofm_dim;
  addr_t ifm_size;
  addr_t wt_base;
  addr_t ifm_base;
  addr_t win_idx;
  addr_t ofm_idx;
  addr_t ifm_row;

  // valid window positions along one edge
  assign ofm_dim  = dim_t'(ifm_dim - dim_t'(WT_DIM - 1));
  assign ifm_size = addr_t'(ifm_dim) * addr_t'(ifm_dim);

  assign window_last = (win_x == dim_t'(WT_DIM - 1)) && (win_y == dim_t'(WT_DIM - 1));
  assign plane_last  = (out_x == dim_t'(ofm_dim - 16'd1)) &&
                       (out_y == dim_t'(ofm_dim - 16'd1));

  // weight and IFM fetch walk the same window position
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_x <= '0;
      win_y <= '0;
    end else if (phase == IDLE) begin
      win_x <= '0;
      win_y <= '0;
    end else if (xfer_wt || xfer_ifm) begin
      if (win_x == dim_t'(WT_DIM - 1)) begin
        win_x <= '0;
        win_y <= window_last ? '0 : win_y + 16'd1;
      end else begin
        win_x <= win_x + 16'd1;
      end
    end
  end

  // output pixel and channel bases move on each OFM write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_x    <= '0;
      out_y    <= '0;
      wt_base  <= '0;
      ifm_base <= '0;
    end else if (phase == IDLE) begin
      out_x    <= '0;
      out_y    <= '0;
      wt_base  <= '0;
      ifm_base <= '0;
    end else if (xfer_wr) begin
      if (plane_last) begin
        out_x    <= '0;
        out_y    <= '0;
        wt_base  <= wt_base + addr_t'(WT_SIZE);
        ifm_base <= ifm_base + ifm_size;
      end else if (out_x == dim_t'(ofm_dim - 16'd1)) begin
        out_x <= '0;
        out_y <= out_y + 16'd1;
      end else begin
        out_x <= out_x + 16'd1;
      end
    end
  end

  assign win_idx = addr_t'(win_y) * addr_t'(WT_DIM) + addr_t'(win_x);
  assign ofm_idx = addr_t'(out_y) * addr_t'(ofm_dim) + addr_t'(out_x);
  assign ifm_row = (addr_t'(out_y) + addr_t'(win_y)) * addr_t'(ifm_dim);

  assign wt_addr     = wt_base + win_idx;
  assign ifm_addr    = ifm_base + ifm_row + addr_t'(out_x) + addr_t'(win_x);
  assign ofm_rd_addr = ofm_idx;
  assign ofm_wr_addr = ofm_idx;

endmodule

`default_nettype wire

//--- src/conv_ctrl.sv
`default_nettype none

module conv_ctrl #(
  parameter int WT_DIM = 5
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                wt_valid,
  input  logic                ifm_valid,
  input  logic                ofm_rd_valid,
  input  logic                ofm_wr_ready,
  input  conv_pkg::dim_t      ifm_depth,
  input  logic                window_last,
  input  logic                plane_last,
  output conv_pkg::phase_e    phase,
  output logic                wt_ready,
  output logic                ifm_ready,
  output logic                ofm_rd_ready,
  output logic                ofm_wr_valid,
  output logic                xfer_wt,
  output logic                xfer_ifm,
  output logic                xfer_ofm,
  output logic                xfer_wr,
  output logic                idle,
  output logic                done
);

  import conv_pkg::*;

  localparam int WT_SIZE = WT_DIM * WT_DIM;

  phase_e phase_d;
  dim_t   ch_cnt;
  dim_t   shift_cnt;
  logic   done_q;
  logic   first_ch;
  logic   last_ch;
  logic   compute_last;
  logic   run_last;

  // each port requests for the whole of its phase
  assign wt_ready     = (phase == FETCH_WT);
  assign ifm_ready    = (phase == FETCH_IFM);
  assign ofm_rd_ready = (phase == FETCH_OFM);
  assign ofm_wr_valid = (phase == WRITE_OFM);

  assign xfer_wt  = wt_ready & wt_valid;
  assign xfer_ifm = ifm_ready & ifm_valid;
  assign xfer_ofm = ofm_rd_ready & ofm_rd_valid;
  assign xfer_wr  = ofm_wr_valid & ofm_wr_ready;

  assign first_ch     = (ch_cnt == '0);
  assign last_ch      = (ch_cnt == dim_t'(ifm_depth - 16'd1));
  assign compute_last = (phase == COMPUTE) && (shift_cnt == dim_t'(WT_SIZE - 1));

  // last OFM element of the last input channel
  assign run_last = xfer_wr & plane_last & last_ch;

  always_comb begin
    phase_d = phase;
    case (phase)
      IDLE: begin
        if (start) begin
          phase_d = FETCH_WT;
        end
      end
      FETCH_WT: begin
        if (xfer_wt && window_last) begin
          phase_d = first_ch ? FETCH_IFM : FETCH_OFM;
        end
      end
      FETCH_OFM: begin
        if (xfer_ofm) begin
          phase_d = FETCH_IFM;
        end
      end
      FETCH_IFM: begin
        if (xfer_ifm && window_last) begin
          phase_d = COMPUTE;
        end
      end
      COMPUTE: begin
        if (compute_last) begin
          phase_d = WRITE_OFM;
        end
      end
      WRITE_OFM: begin
        if (xfer_wr) begin
          if (plane_last) begin
            // weights of the next channel, or finished
            phase_d = last_ch ? DONE : FETCH_WT;
          end else begin
            phase_d = first_ch ? FETCH_IFM : FETCH_OFM;
          end
        end
      end
      default: begin
        phase_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= IDLE;
      ch_cnt    <= '0;
      shift_cnt <= '0;
      done_q    <= 1'b0;
    end else begin
      phase <= phase_d;

      if (phase == IDLE) begin
        ch_cnt <= '0;
      end else if (xfer_wr && plane_last && !last_ch) begin
        ch_cnt <= ch_cnt + 16'd1;
      end

      // one product per compute cycle
      if (compute_last) begin
        shift_cnt <= '0;
      end else if (phase == COMPUTE) begin
        shift_cnt <= shift_cnt + 16'd1;
      end

      if (run_last) begin
        done_q <= 1'b1;
      end else if (idle && start) begin
        done_q <= 1'b0;
      end
    end
  end

  assign idle = (phase == IDLE);

  // drops in the same cycle the next start is taken
  assign done = done_q & ~(idle & start);

endmodule

`default_nettype wire

//--- src/conv_pkg.sv
`default_nettype none

package conv_pkg;

  // signed feature map or weight element
  typedef logic signed [7:0] pixel_t;

  // accumulator and OFM word
  typedef logic signed [31:0] acc_t;

  // word address on every memory port
  typedef logic [31:0] addr_t;

  // dimensions, depths and loop counters
  typedef logic [15:0] dim_t;

  // controller phases
  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    FETCH_OFM = 3'd1,
    FETCH_WT  = 3'd2,
    FETCH_IFM = 3'd3,
    COMPUTE   = 3'd4,
    WRITE_OFM = 3'd5,
    DONE      = 3'd6
  } phase_e;

endpackage

`default_nettype wire
